//--- Bender.yml
package:
  name: alu_rs

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/rv_isa_pkg.sv
      - rtl/ooo_pkg.sv
      - rtl/rs_if.sv
      - rtl/rs_dispatch.sv
      - rtl/rs_entry.sv
      - rtl/rs_issue_alu.sv
      - rtl/alu_rs_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/alu_rs_props.sv
      - tb/alu_rs_tb.sv

//--- flist.f
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/ooo_pkg.sv
rtl/rs_if.sv
rtl/rs_dispatch.sv
rtl/rs_entry.sv
rtl/rs_issue_alu.sv
rtl/alu_rs_top.sv
tb/alu_rs_props.sv
tb/alu_rs_tb.sv

//--- rtl/alu_rs_top.sv
/* integer issue slice, OP and OP-IMM only.
   dispatcher must watch rs_full, a strobe while full is dropped */
`timescale 1ns/100ps
`default_nettype none

`include "rs_config.svh"

module alu_rs_top import ooo_pkg::*; (
    input  logic        clk_in,
    input  logic        rst,
    input  logic        rdy_in,
    input  logic        clr,
    input  logic        disp_en,
    input  logic [31:0] disp_inst,
    input  nick_t       disp_rd_nick,
    input  operand_t    disp_src1,
    input  operand_t    disp_src2,
    input  logic        ext_en,
    input  nick_t       ext_nick,
    input  data_t       ext_dt,
    output logic        cdb_en,
    output nick_t       cdb_nick,
    output data_t       cdb_dt,
    output logic        rs_full
);

    cdb_t alu_cdb;
    cdb_t ext_cdb;

    dispatch_if disp_ifs [`RS_DEPTH] ();
    issue_if    iss_ifs [`RS_DEPTH] ();

    // load results from the load/store buffer
    assign ext_cdb = '{en: ext_en, nick: ext_nick, dt: ext_dt};

    rs_dispatch u_dispatch (
        .clk          (clk_in),
        .rst          (rst),
        .rdy          (rdy_in),
        .disp_en      (disp_en),
        .disp_inst    (disp_inst),
        .disp_rd_nick (disp_rd_nick),
        .disp_src1    (disp_src1),
        .disp_src2    (disp_src2),
        .alu_cdb      (alu_cdb),
        .ext_cdb      (ext_cdb),
        .ent          (disp_ifs),
        .rs_full      (rs_full)
    );

    for (genvar i = 0; i < `RS_DEPTH; i++) begin : g_rs
        rs_entry u_entry (
            .clk     (clk_in),
            .rst     (rst),
            .rdy     (rdy_in),
            .clr     (clr),
            .disp    (disp_ifs[i]),
            .iss     (iss_ifs[i]),
            .alu_cdb (alu_cdb),
            .ext_cdb (ext_cdb)
        );
    end

    rs_issue_alu u_issue (
        .clk     (clk_in),
        .rst     (rst),
        .rdy     (rdy_in),
        .clr     (clr),
        .ent     (iss_ifs),
        .alu_cdb (alu_cdb)
    );

    assign cdb_en   = alu_cdb.en;
    assign cdb_nick = alu_cdb.nick;
    assign cdb_dt   = alu_cdb.dt;

endmodule

`default_nettype wire

//--- rtl/ooo_pkg.sv
/* types shared by the out-of-order blocks.
   widths follow the station config macros */
`default_nettype none

`include "rs_config.svh"

package ooo_pkg;

    typedef logic [`NICK_W-1:0]   nick_t;
    typedef logic [`XLEN-1:0]     data_t;
    typedef logic [`RS_DEPTH-1:0] ent_vec_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    // valid means dt holds the value, otherwise wait for nick
    typedef struct packed {
        logic  valid;
        nick_t nick;
        data_t dt;
    } operand_t;

    typedef struct packed {
        logic  en;
        nick_t nick;
        data_t dt;
    } cdb_t;

    // fill a waiting operand from whichever bus carries its nick
    function automatic operand_t fwd_operand(operand_t src, cdb_t a, cdb_t b);
        operand_t res;
        res = src;
        if (!src.valid) begin
            if (a.en && a.nick == src.nick) begin
                res.valid = 1'b1;
                res.dt    = a.dt;
            end else if (b.en && b.nick == src.nick) begin
                res.valid = 1'b1;
                res.dt    = b.dt;
            end
        end
        return res;
    endfunction

    // one-hot of the lowest set bit, zero when none set
    function automatic ent_vec_t pick_lowest(ent_vec_t v);
        return v & (~v + 1'b1);
    endfunction

endpackage

`default_nettype wire

//--- rtl/rs_config.svh
/* station sizing, shared by the packages and the RTL.
   NICK_W must cover every rename tag the dispatcher can hand out */
`ifndef RS_CONFIG_SVH
`define RS_CONFIG_SVH

// number of reservation station entries
`define RS_DEPTH 4

// rename tag width, one nick per in-flight result
`define NICK_W 4

// data path width, fixed by RV32I
`define XLEN 32

`endif

//--- rtl/rs_dispatch.sv
/* no back-pressure, a strobe while full or with another opcode is lost.
   src2 is ignored for OP-IMM, the immediate takes its place */
`timescale 1ns/100ps
`default_nettype none

`include "rs_config.svh"

module rs_dispatch
    import rv_isa_pkg::*;
    import ooo_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  logic           rdy,
    input  logic           disp_en,
    input  inst_u          disp_inst,
    input  nick_t          disp_rd_nick,
    input  operand_t       disp_src1,
    input  operand_t       disp_src2,
    input  cdb_t           alu_cdb,
    input  cdb_t           ext_cdb,
    dispatch_if.dispatcher ent [`RS_DEPTH],
    output logic           rs_full
);

    alu_op_e  op;
    operand_t src2_dec;
    operand_t src1_fwd;
    operand_t src2_fwd;
    logic     opc_ok;
    logic     take;
    ent_vec_t busy_vec;
    ent_vec_t load_vec;

    // sub selects SUB over ADD, sra selects SRA over SRL
    function automatic alu_op_e to_alu_op(funct3_e f3, logic sub, logic sra);
        case (f3)
            F3_ADD:  return sub ? ALU_SUB : ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return sra ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        op       = ALU_ADD;
        src2_dec = disp_src2;
        opc_ok   = 1'b0;
        case (disp_inst.r.opcode)
            OPC_OP: begin
                opc_ok = 1'b1;
                op     = to_alu_op(disp_inst.r.funct3, disp_inst.r.funct7[5],
                                   disp_inst.r.funct7[5]);
            end
            OPC_OP_IMM: begin
                opc_ok         = 1'b1;
                op             = to_alu_op(disp_inst.i.funct3, 1'b0, disp_inst.i.imm12[10]);
                src2_dec.valid = 1'b1;
                src2_dec.nick  = '0;
                src2_dec.dt    = {{(`XLEN-12){disp_inst.i.imm12[11]}}, disp_inst.i.imm12};
            end
            default: ;
        endcase
    end

    // same-cycle broadcast would otherwise be missed by the new entry
    assign src1_fwd = fwd_operand(disp_src1, alu_cdb, ext_cdb);
    assign src2_fwd = fwd_operand(src2_dec, alu_cdb, ext_cdb);

    assign take     = disp_en && rdy && opc_ok && !rs_full;
    assign load_vec = take ? pick_lowest(~busy_vec) : '0;
    assign rs_full  = &busy_vec;

    for (genvar i = 0; i < `RS_DEPTH; i++) begin : g_ent
        assign busy_vec[i]    = ent[i].busy;
        assign ent[i].load    = load_vec[i];
        assign ent[i].op      = op;
        assign ent[i].rd_nick = disp_rd_nick;
        assign ent[i].src1    = src1_fwd;
        assign ent[i].src2    = src2_fwd;
    end

endmodule

`default_nettype wire

//--- rtl/rs_entry.sv
/* one station slot. grant is trusted, readiness is not rechecked.
   clr wins over a load in the same cycle */
`timescale 1ns/100ps
`default_nettype none

module rs_entry import ooo_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      rdy,
    input  logic      clr,
    dispatch_if.entry disp,
    issue_if.entry    iss,
    input  cdb_t      alu_cdb,
    input  cdb_t      ext_cdb
);

    logic     busy_q;
    alu_op_e  op_q;
    nick_t    rd_nick_q;
    operand_t src1_q;
    operand_t src2_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
        end else if (rdy) begin
            if (clr) begin
                busy_q <= 1'b0;
            end else if (disp.load) begin
                busy_q <= 1'b1;
            end else if (iss.grant) begin
                busy_q <= 1'b0;
            end
        end
    end

    // payload, meaningful only while busy
    always_ff @(posedge clk) begin
        if (rdy) begin
            if (disp.load) begin
                op_q      <= disp.op;
                rd_nick_q <= disp.rd_nick;
                src1_q    <= disp.src1;
                src2_q    <= disp.src2;
            end else begin
                // snoop both buses for missing operands
                src1_q <= fwd_operand(src1_q, alu_cdb, ext_cdb);
                src2_q <= fwd_operand(src2_q, alu_cdb, ext_cdb);
            end
        end
    end

    assign disp.busy = busy_q;

    // a capture this cycle shows up as ready next cycle
    assign iss.ready   = busy_q && src1_q.valid && src2_q.valid;
    assign iss.op      = op_q;
    assign iss.rd_nick = rd_nick_q;
    assign iss.v1      = src1_q.dt;
    assign iss.v2      = src2_q.dt;

endmodule

`default_nettype wire

//--- rtl/rs_if.sv
/* per-entry links between dispatch, the station entries and issue.
   one instance of each interface per entry */
`timescale 1ns/100ps
`default_nettype none

interface dispatch_if import ooo_pkg::*; ();
    // load is a single-cycle strobe, only ever sent to a free entry
    logic     load;
    alu_op_e  op;
    nick_t    rd_nick;
    operand_t src1;
    operand_t src2;
    logic     busy;

    modport dispatcher (
        output load, op, rd_nick, src1, src2,
        input  busy
    );

    modport entry (
        input  load, op, rd_nick, src1, src2,
        output busy
    );
endinterface

interface issue_if import ooo_pkg::*; ();
    logic    ready;
    alu_op_e op;
    nick_t   rd_nick;
    data_t   v1;
    data_t   v2;
    // entry frees itself on the edge after grant
    logic    grant;

    modport entry (
        output ready, op, rd_nick, v1, v2,
        input  grant
    );

    modport issuer (
        input  ready, op, rd_nick, v1, v2,
        output grant
    );
endinterface

`default_nettype wire

//--- rtl/rs_issue_alu.sv
/* fixed priority, the lowest ready entry always wins.
   one issue per cycle, result on the CDB one cycle after grant */
`timescale 1ns/100ps
`default_nettype none

`include "rs_config.svh"

module rs_issue_alu import ooo_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    rdy,
    input  logic    clr,
    issue_if.issuer ent [`RS_DEPTH],
    output cdb_t    alu_cdb
);

    ent_vec_t ready_vec;
    ent_vec_t grant_vec;
    logic     go;
    alu_op_e  op_a [`RS_DEPTH];
    nick_t    nick_a [`RS_DEPTH];
    data_t    v1_a [`RS_DEPTH];
    data_t    v2_a [`RS_DEPTH];
    alu_op_e  sel_op;
    nick_t    sel_nick;
    data_t    sel_v1;
    data_t    sel_v2;
    data_t    res;
    logic [4:0] shamt;
    logic     en_q;
    nick_t    nick_q;
    data_t    dt_q;

    for (genvar i = 0; i < `RS_DEPTH; i++) begin : g_ent
        assign ready_vec[i] = ent[i].ready;
        assign op_a[i]      = ent[i].op;
        assign nick_a[i]    = ent[i].rd_nick;
        assign v1_a[i]      = ent[i].v1;
        assign v2_a[i]      = ent[i].v2;
        assign ent[i].grant = grant_vec[i];
    end

    // no grant while stalled or flushing
    assign go        = rdy && !clr && (|ready_vec);
    assign grant_vec = go ? pick_lowest(ready_vec) : '0;

    // one-hot select of the granted entry
    always_comb begin
        sel_op   = ALU_ADD;
        sel_nick = '0;
        sel_v1   = '0;
        sel_v2   = '0;
        for (int k = 0; k < `RS_DEPTH; k++) begin
            if (grant_vec[k]) begin
                sel_op   = op_a[k];
                sel_nick = nick_a[k];
                sel_v1   = v1_a[k];
                sel_v2   = v2_a[k];
            end
        end
    end

    assign shamt = sel_v2[4:0];

    always_comb begin
        case (sel_op)
            ALU_ADD:  res = sel_v1 + sel_v2;
            ALU_SUB:  res = sel_v1 - sel_v2;
            ALU_SLL:  res = sel_v1 << shamt;
            ALU_SLT:  res = data_t'($signed(sel_v1) < $signed(sel_v2));
            ALU_SLTU: res = data_t'(sel_v1 < sel_v2);
            ALU_XOR:  res = sel_v1 ^ sel_v2;
            ALU_SRL:  res = sel_v1 >> shamt;
            ALU_SRA:  res = data_t'($signed(sel_v1) >>> shamt);
            ALU_OR:   res = sel_v1 | sel_v2;
            default:  res = sel_v1 & sel_v2;
        endcase
    end

    // en drops after a flush since go is low during clr
    always_ff @(posedge clk) begin
        if (rst) begin
            en_q <= 1'b0;
        end else if (rdy) begin
            en_q <= go;
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            nick_q <= sel_nick;
            dt_q   <= res;
        end
    end

    assign alu_cdb = '{en: en_q, nick: nick_q, dt: dt_q};

endmodule

`default_nettype wire

//--- rtl/rv_isa_pkg.sv
/* RV32I encodings for the OP and OP-IMM groups only.
   other opcodes are not described here */
`default_nettype none

package rv_isa_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011
    } opcode_e;

    // SR covers both logical and arithmetic shifts
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101,
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } funct3_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        funct3_e    funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        funct3_e     funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_type_t;

    // opcode, funct3 and rd sit at the same bits in both views
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } inst_u;

endpackage

`default_nettype wire

//--- tb/alu_rs_props.sv
/* handshake assertions bound into alu_rs_top.
   a broadcast or dispatch counts only on an edge with rdy_in high */
`timescale 1ns/100ps
`default_nettype none

`include "rs_config.svh"

module alu_rs_props import ooo_pkg::*; (
    input logic  clk_in,
    input logic  rst,
    input logic  rdy_in,
    input logic  clr,
    input logic  disp_en,
    input nick_t disp_rd_nick,
    input logic  cdb_en,
    input nick_t cdb_nick,
    input logic  rs_full
);

    // nicks already broadcast since their last dispatch
    logic [(1 << `NICK_W)-1:0] seen_q;
    int unsigned               fail_cnt = 0;

    always_ff @(posedge clk_in) begin
        if (rst) begin
            seen_q <= '0;
        end else if (rdy_in) begin
            if (cdb_en) begin
                seen_q[cdb_nick] <= 1'b1;
            end
            if (disp_en && !rs_full && !clr) begin
                seen_q[disp_rd_nick] <= 1'b0;
            end
        end
    end

    a_cdb_once: assert property (@(posedge clk_in) disable iff (rst)
        (cdb_en && rdy_in) |-> !seen_q[cdb_nick])
        else begin
            fail_cnt++;
            $error("nick %0d broadcast twice without a dispatch in between", cdb_nick);
        end

    a_full_after_rst: assert property (@(posedge clk_in) rst |=> !rs_full)
        else begin
            fail_cnt++;
            $error("rs_full high after reset");
        end

    a_clr_quiet: assert property (@(posedge clk_in) disable iff (rst)
        (clr && rdy_in) |=> !cdb_en)
        else begin
            fail_cnt++;
            $error("cdb_en high in the cycle after a flush");
        end

endmodule

bind alu_rs_top alu_rs_props props_i (.*);

`default_nettype wire

//--- tb/alu_rs_tb.sv
/* random OP/OP-IMM traffic with stalls and flushes, checked against a model.
   a nick is never reused while in flight, dispatch only while rs_full is low */
`timescale 1ns/100ps
`default_nettype none

`include "rs_config.svh"

module alu_rs_tb import rv_isa_pkg::*; import ooo_pkg::*; ();

    localparam int NICKS = 1 << `NICK_W;
    localparam logic [1:0] K_FREE = 2'd0;
    localparam logic [1:0] K_ALU  = 2'd1;
    localparam logic [1:0] K_EXT  = 2'd2;

    logic        clk_in;
    logic        rst;
    logic        rdy_in;
    logic        clr;
    logic        disp_en;
    logic [31:0] disp_inst;
    nick_t       disp_rd_nick;
    operand_t    disp_src1;
    operand_t    disp_src2;
    logic        ext_en;
    nick_t       ext_nick;
    data_t       ext_dt;
    logic        cdb_en;
    nick_t       cdb_nick;
    data_t       cdb_dt;
    logic        rs_full;

    // model state, indexed by nick
    logic [1:0] kind [NICKS];
    data_t      exp_val [NICKS];
    int         disp_cyc [NICKS];
    int         outstanding;
    int         ext_pending;
    int         cyc;
    int         mismatch_cnt;
    int         other_cnt;
    int         stall_left;
    bit         iso_mode;
    bit         hung;

    alu_rs_top dut_i (
        .clk_in       (clk_in),
        .rst          (rst),
        .rdy_in       (rdy_in),
        .clr          (clr),
        .disp_en      (disp_en),
        .disp_inst    (disp_inst),
        .disp_rd_nick (disp_rd_nick),
        .disp_src1    (disp_src1),
        .disp_src2    (disp_src2),
        .ext_en       (ext_en),
        .ext_nick     (ext_nick),
        .ext_dt       (ext_dt),
        .cdb_en       (cdb_en),
        .cdb_nick     (cdb_nick),
        .cdb_dt       (cdb_dt),
        .rs_full      (rs_full)
    );

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    // RV32I result, b is rs2 or the sign-extended immediate
    function automatic data_t model_alu(inst_u w, data_t a, data_t b);
        logic [4:0]  sh;
        logic        alt;
        logic [63:0] a_ext;
        sh    = b[4:0];
        alt   = (w.r.opcode == OPC_OP) ? w.r.funct7[5] : w.i.imm12[10];
        a_ext = {{32{a[31]}}, a};
        case (w.r.funct3)
            F3_ADD:  return (w.r.opcode == OPC_OP && alt) ? a - b : a + b;
            F3_SLL:  return a << sh;
            F3_SLT:  return {31'b0, $signed(a) < $signed(b)};
            F3_SLTU: return {31'b0, a < b};
            F3_XOR:  return a ^ b;
            F3_SR:   return alt ? data_t'(a_ext >> sh) : a >> sh;
            F3_OR:   return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic inst_u make_word(bit is_imm, logic [2:0] f3, bit alt);
        inst_u w;
        w          = inst_u'($urandom);
        w.r.funct3 = funct3_e'(f3);
        if (is_imm) begin
            w.i.opcode = OPC_OP_IMM;
            // shift immediates carry only shamt and the arithmetic bit
            if (f3 == 3'd1 || f3 == 3'd5) begin
                w.i.imm12[11:5] = {1'b0, alt, 5'b0};
            end
        end else begin
            w.r.opcode = OPC_OP;
            w.r.funct7 = {1'b0, alt, 5'b0};
        end
        return w;
    endfunction

    // random start so that nicks get spread around
    function automatic bit find_nick(logic [1:0] k, output nick_t n);
        int start;
        start = $urandom % NICKS;
        for (int i = 0; i < NICKS; i++) begin
            if (kind[(start + i) % NICKS] == k) begin
                n = nick_t'((start + i) % NICKS);
                return 1'b1;
            end
        end
        n = '0;
        return 1'b0;
    endfunction

    function automatic bit nicks_in_flight();
        for (int i = 0; i < NICKS; i++) begin
            if (kind[i] != K_FREE) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic check_cdb(input cdb_t got);
        if (kind[got.nick] != K_ALU) begin
            $display("%0t: nick %0d on the CDB is not in flight", $time, got.nick);
            other_cnt++;
        end else begin
            if (got.dt !== exp_val[got.nick]) begin
                $display("mismatch at %0t: cdb_dt nick %0d got %h expected %h",
                         $time, got.nick, got.dt, exp_val[got.nick]);
                mismatch_cnt++;
            end
            if (iso_mode && cyc - disp_cyc[got.nick] != 2) begin
                $display("mismatch at %0t: latency nick %0d got %0d expected 2",
                         $time, got.nick, cyc - disp_cyc[got.nick]);
                mismatch_cnt++;
            end
            kind[got.nick] = K_FREE;
            outstanding--;
        end
    endtask

    task automatic check_full(input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: rs_full got %b expected %b", $time, got, exp);
            mismatch_cnt++;
        end
    endtask

    // a result on the bus has already left its entry
    always @(posedge clk_in) begin
        if (!rst) begin
            check_full(rs_full, (outstanding - int'(cdb_en)) == `RS_DEPTH);
            if (rdy_in) begin
                if (cdb_en) begin
                    check_cdb('{en: cdb_en, nick: cdb_nick, dt: cdb_dt});
                end
                if (ext_en) begin
                    kind[ext_nick] = K_FREE;
                    ext_pending--;
                end
                if (disp_en) begin
                    outstanding++;
                    disp_cyc[disp_rd_nick] = cyc;
                end
                if (clr) begin
                    for (int i = 0; i < NICKS; i++) begin
                        if (kind[i] == K_ALU) begin
                            kind[i] = K_FREE;
                        end
                    end
                    outstanding = 0;
                end
            end
            cyc++;
        end
    end

    // immediate, pending ALU nick, or a load nick returned later on ext
    task automatic pick_source(output operand_t src, output data_t val);
        int    r;
        nick_t n;
        r   = $urandom % 3;
        src = '{valid: 1'b1, nick: nick_t'($urandom), dt: data_t'($urandom)};
        val = src.dt;
        if (r == 1 && find_nick(K_ALU, n)) begin
            src = '{valid: 1'b0, nick: n, dt: data_t'($urandom)};
            val = exp_val[n];
        end else if (r == 2) begin
            if (ext_pending < 3 && $urandom % 2 == 0 && find_nick(K_FREE, n)) begin
                kind[n]    = K_EXT;
                exp_val[n] = data_t'($urandom);
                ext_pending++;
            end
            if (find_nick(K_EXT, n)) begin
                src = '{valid: 1'b0, nick: n, dt: data_t'($urandom)};
                val = exp_val[n];
            end
        end
    endtask

    task automatic send(input inst_u w, input operand_t s1, input operand_t s2,
                        input data_t a, input data_t b, output nick_t n);
        data_t b_eff;
        if (find_nick(K_FREE, n)) begin
            b_eff = (w.r.opcode == OPC_OP_IMM) ?
                    {{(`XLEN-12){w.i.imm12[11]}}, w.i.imm12} : b;
            kind[n]      = K_ALU;
            exp_val[n]   = model_alu(w, a, b_eff);
            disp_en      = 1'b1;
            disp_inst    = w;
            disp_rd_nick = n;
            disp_src1    = s1;
            disp_src2    = s2;
        end
    endtask

    task automatic drive_cycle(input bit allow_disp, input bit allow_stall,
                               input bit allow_clr);
        inst_u      w;
        operand_t   s1;
        operand_t   s2;
        data_t      a;
        data_t      b;
        nick_t      n;
        logic [2:0] f3;
        bit         is_imm;
        @(negedge clk_in);
        disp_en = 1'b0;
        ext_en  = 1'b0;
        clr     = 1'b0;
        if (stall_left > 0) begin
            stall_left--;
            rdy_in = 1'b0;
        end else begin
            rdy_in = 1'b1;
            if (allow_stall && $urandom % 10 == 0) begin
                stall_left = 1 + $urandom % 4;
            end
        end
        if (rdy_in && allow_clr && $urandom % 50 == 0) begin
            clr = 1'b1;
        end else if (rdy_in) begin
            if (allow_disp && !rs_full && $urandom % 3 != 0) begin
                f3     = 3'($urandom);
                is_imm = $urandom % 2;
                w = make_word(is_imm, f3,
                              ($urandom % 2) && (f3 == 3'd5 || (f3 == 3'd0 && !is_imm)));
                pick_source(s1, a);
                pick_source(s2, b);
                send(w, s1, s2, a, b, n);
            end
            if ($urandom % 3 == 0 && find_nick(K_EXT, n)) begin
                ext_en   = 1'b1;
                ext_nick = n;
                ext_dt   = exp_val[n];
            end
        end
    endtask

    task automatic wait_done(input nick_t n);
        int t;
        t = 0;
        while (kind[n] != K_FREE && t < 20) begin
            drive_cycle(1'b0, 1'b0, 1'b0);
            t++;
        end
        if (kind[n] != K_FREE) begin
            $display("timeout: nick %0d never appeared on the CDB", n);
            other_cnt++;
            hung = 1'b1;
        end
    endtask

    // one instruction alone in the station, both operands known
    task automatic run_directed(input bit is_imm, input logic [2:0] f3, input bit alt);
        operand_t s1;
        operand_t s2;
        nick_t    n;
        if (!hung) begin
            @(negedge clk_in);
            rdy_in = 1'b1;
            s1 = '{valid: 1'b1, nick: '0, dt: data_t'($urandom)};
            s2 = '{valid: 1'b1, nick: '0, dt: data_t'($urandom)};
            send(make_word(is_imm, f3, alt), s1, s2, s1.dt, s2.dt, n);
            wait_done(n);
        end
    endtask

    initial begin
        int t;
        void'($urandom(32'hd1c3));
        rst          = 1'b1;
        rdy_in       = 1'b1;
        clr          = 1'b0;
        disp_en      = 1'b0;
        disp_inst    = '0;
        disp_rd_nick = '0;
        disp_src1    = '0;
        disp_src2    = '0;
        ext_en       = 1'b0;
        ext_nick     = '0;
        ext_dt       = '0;
        for (int i = 0; i < NICKS; i++) begin
            kind[i]     = K_FREE;
            exp_val[i]  = '0;
            disp_cyc[i] = 0;
        end
        outstanding  = 0;
        ext_pending  = 0;
        cyc          = 0;
        mismatch_cnt = 0;
        other_cnt    = 0;
        stall_left   = 0;
        hung         = 1'b0;
        repeat (5) @(posedge clk_in);
        @(negedge clk_in);
        rst = 1'b0;

        // every ALU operation in R and I form, fixed two-cycle latency
        iso_mode = 1'b1;
        for (int f = 0; f < 8; f++) begin
            run_directed(1'b0, 3'(f), 1'b0);
            if (f == 0 || f == 5) begin
                run_directed(1'b0, 3'(f), 1'b1);
            end
            run_directed(1'b1, 3'(f), 1'b0);
            if (f == 5) begin
                run_directed(1'b1, 3'(f), 1'b1);
            end
        end
        iso_mode = 1'b0;

        for (int i = 0; i < 1500 && !hung; i++) begin
            drive_cycle(1'b1, 1'b1, 1'b1);
        end

        // drain, returning the remaining load nicks
        t = 0;
        while (!hung && nicks_in_flight() && t < 300) begin
            drive_cycle(1'b0, 1'b0, 1'b0);
            t++;
        end
        if (nicks_in_flight()) begin
            $display("timeout: nicks still in flight after the drain");
            other_cnt++;
        end
        @(negedge clk_in);

        $display("errors: %0d mismatch, %0d other, %0d assertion",
                 mismatch_cnt, other_cnt, dut_i.props_i.fail_cnt);
        if (mismatch_cnt + other_cnt + dut_i.props_i.fail_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
